/* Bender.yml */
package:
  name: irq_sleep_unit

sources:
  - irq_sleep_pkg.sv
  - irq_csr.sv
  - irq_arbiter.sv
  - bus_outstanding_cnt.sv
  - wfi_decode.sv
  - sleep_ctrl.sv
  - irq_sleep_unit.sv
  - target: simulation
    files:
      - tb_irq_sleep_unit.sv

/* bus_outstanding_cnt.sv */
module bus_outstanding_cnt (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  irq_sleep_pkg::bus_strobe_t bus_i,
  output logic                       busy_o
);
  import irq_sleep_pkg::*;

  logic [OutstandingWidth-1:0] cnt_q;
  logic                        issue;
  logic                        inc;
  logic                        dec;

  // A request counts once it is granted
  assign issue = bus_i.req && bus_i.gnt;
  assign inc   = issue && !bus_i.rvalid;
  assign dec   = bus_i.rvalid && !issue;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (inc) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (dec) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign busy_o = |cnt_q;

  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni) dec |-> cnt_q != '0);

  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_ni) inc |-> cnt_q != '1);

endmodule

/* irq_arbiter.sv */
module irq_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  irq_sleep_pkg::irq_vec_t   irq_i,
  input  irq_sleep_pkg::csr_state_t csr_i,
  input  logic                      debug_mode_i,
  output irq_sleep_pkg::irq_vec_t   mip_o,
  output logic                      irq_wake_o,
  output logic                      irq_ack_o,
  output irq_sleep_pkg::irq_id_t    irq_id_o
);
  import irq_sleep_pkg::*;

  irq_vec_t mip_q;
  irq_vec_t pend_en;
  irq_id_t  win_id;
  logic     win_valid;
  logic     eligible;

  // Reserved lines never reach mip
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & ValidIrqMask;
    end
  end

  assign pend_en = mip_q & csr_i.mie;

  // --------------------------------------------------------------------------
  // Fixed priority of 31..16, then 11, 3 and 7, with the last match winning
  // --------------------------------------------------------------------------
  always_comb begin
    win_id = '0;
    if (pend_en[7]) begin
      win_id = irq_id_t'(7);
    end
    if (pend_en[3]) begin
      win_id = irq_id_t'(3);
    end
    if (pend_en[11]) begin
      win_id = irq_id_t'(11);
    end
    for (int i = 16; i < NumIrq; i++) begin
      if (pend_en[i]) begin
        win_id = irq_id_t'(i);
      end
    end
  end

  assign win_valid = |pend_en;
  // U-mode takes any enabled interrupt regardless of mstatus.mie
  assign eligible  = ((csr_i.priv_lvl == PrivM) && csr_i.mstatus_mie) ||
                     ((csr_i.priv_lvl == PrivU) && win_valid);

  assign irq_ack_o  = win_valid && eligible && !debug_mode_i;
  assign irq_id_o   = win_id;
  assign irq_wake_o = win_valid;
  assign mip_o      = mip_q;

  a_ack_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni) irq_ack_o |=> !irq_ack_o);

  a_ack_id_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> ValidIrqMask[irq_id_o] && csr_i.mie[irq_id_o]);

  a_mip_not_reserved: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (mip_o & ~ValidIrqMask) == '0);

endmodule

/* irq_csr.sv */
module irq_csr (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  irq_sleep_pkg::csr_wr_t   csr_wr_i,
  input  logic                     mret_i,
  input  irq_sleep_pkg::priv_lvl_e priv_i,
  input  logic                     irq_ack_i,
  input  irq_sleep_pkg::irq_id_t   irq_id_i,
  output irq_sleep_pkg::csr_state_t csr_o
);
  import irq_sleep_pkg::*;

  csr_state_t csr_q;

  // Later statements win, so the order below is mret, trap entry, CSR write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csr_q          <= '0;
      csr_q.priv_lvl <= PrivM;
    end else begin
      if (mret_i) begin
        csr_q.mstatus_mie <= csr_q.mstatus_mpie;
        csr_q.priv_lvl    <= priv_i;
      end

      // Trap entry on acknowledge
      if (irq_ack_i) begin
        csr_q.mstatus_mie  <= 1'b0;
        csr_q.mstatus_mpie <= csr_q.mstatus_mie;
        csr_q.mcause.irq   <= 1'b1;
        csr_q.mcause.id    <= irq_id_i;
        csr_q.priv_lvl     <= PrivM;
      end

      if (csr_wr_i.valid) begin
        case (csr_wr_i.sel)
          CsrMie: begin
            csr_q.mie <= csr_wr_i.data;
          end
          CsrMstatus: begin
            csr_q.mstatus_mie  <= csr_wr_i.data[3];
            csr_q.mstatus_mpie <= csr_wr_i.data[7];
            csr_q.mstatus_tw   <= csr_wr_i.data[21];
          end
          CsrMtvec: begin
            csr_q.mtvec_mode <= csr_wr_i.data[0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  assign csr_o = csr_q;

  // The arbiter must respect global enable as seen by this register
  a_no_ack_when_disabled: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i |-> !((csr_q.priv_lvl == PrivM) && !csr_q.mstatus_mie)
  );

endmodule

/* irq_sleep_pkg.sv */
package irq_sleep_pkg;

  // --------------------------------------------------------------------------
  // Constants
  // --------------------------------------------------------------------------

  localparam int unsigned NumIrq     = 32;
  localparam int unsigned IrqIdWidth = 5;

  // Lines 31..16 are platform interrupts, 11/7/3 are external, timer, software
  localparam logic [NumIrq-1:0] ValidIrqMask = 32'hffff_0888;

  localparam logic [31:0] WfiInstr = 32'h1050_0073;
  localparam logic [31:0] WfeInstr = 32'h8c00_0073;

  // Cycles a wait instruction sits in writeback before sleep may start
  localparam int unsigned SleepEntryDelay  = 2;
  localparam int unsigned OutstandingWidth = 4;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  typedef logic [NumIrq-1:0]     irq_vec_t;
  typedef logic [IrqIdWidth-1:0] irq_id_t;

  typedef enum logic [1:0] {
    PrivU = 2'b00,
    PrivM = 2'b11
  } priv_lvl_e;

  typedef enum logic [1:0] {
    CsrMie     = 2'd0,
    CsrMstatus = 2'd1,
    CsrMtvec   = 2'd2
  } csr_sel_e;

  typedef struct packed {
    logic        valid;
    csr_sel_e    sel;
    logic [31:0] data;
  } csr_wr_t;

  typedef struct packed {
    irq_vec_t  mie;
    logic      mstatus_mie;
    logic      mstatus_mpie;
    logic      mstatus_tw;
    logic      mtvec_mode;
    priv_lvl_e priv_lvl;
    struct packed {
      logic    irq;
      irq_id_t id;
    } mcause;
  } csr_state_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic        err;
    logic        mpu_fault;
    logic        kill;
  } wb_instr_t;

  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
  } bus_strobe_t;

endpackage

/* irq_sleep_unit.sv */
module irq_sleep_unit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  irq_sleep_pkg::irq_vec_t    irq_i,
  input  irq_sleep_pkg::csr_wr_t     csr_wr_i,
  input  logic                       mret_i,
  input  irq_sleep_pkg::priv_lvl_e   priv_i,
  input  logic                       debug_mode_i,
  input  logic                       debug_req_i,
  input  logic                       dcsr_step_i,
  input  irq_sleep_pkg::wb_instr_t   wb_instr_i,
  input  irq_sleep_pkg::bus_strobe_t ibus_i,
  input  irq_sleep_pkg::bus_strobe_t dbus_i,
  input  logic                       write_buf_empty_i,
  output irq_sleep_pkg::irq_vec_t    mip_o,
  output logic                       irq_ack_o,
  output irq_sleep_pkg::irq_id_t     irq_id_o,
  output irq_sleep_pkg::csr_state_t  csr_o,
  output logic                       core_sleep_o,
  output logic                       wb_retire_o
);

  logic irq_wake;
  logic ibus_busy;
  logic dbus_busy;
  logic wfi_in_wb;

  // --------------------------------------------------------------------------
  // Interrupt path
  // --------------------------------------------------------------------------
  irq_csr irq_csr_inst (
    .clk_i, .rst_ni, .csr_wr_i, .mret_i, .priv_i,
    .irq_ack_i (irq_ack_o),
    .irq_id_i  (irq_id_o),
    .csr_o
  );

  irq_arbiter irq_arbiter_inst (
    .clk_i, .rst_ni, .irq_i,
    .csr_i      (csr_o),
    .debug_mode_i, .mip_o,
    .irq_wake_o (irq_wake),
    .irq_ack_o, .irq_id_o
  );

  // --------------------------------------------------------------------------
  // Sleep path
  // --------------------------------------------------------------------------
  bus_outstanding_cnt ibus_cnt (.clk_i, .rst_ni, .bus_i(ibus_i), .busy_o(ibus_busy));
  bus_outstanding_cnt dbus_cnt (.clk_i, .rst_ni, .bus_i(dbus_i), .busy_o(dbus_busy));

  wfi_decode wfi_decode_inst (
    .wb_instr_i, .csr_i(csr_o), .debug_mode_i, .dcsr_step_i,
    .wfi_in_wb_o (wfi_in_wb)
  );

  sleep_ctrl sleep_ctrl_inst (
    .clk_i, .rst_ni,
    .wfi_in_wb_i (wfi_in_wb),
    .dcsr_step_i, .debug_req_i,
    .irq_wake_i  (irq_wake),
    .ibus_busy_i (ibus_busy),
    .dbus_busy_i (dbus_busy),
    .write_buf_empty_i, .core_sleep_o, .wb_retire_o
  );

endmodule

/* sleep_ctrl.sv */
module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic wfi_in_wb_i,
  input  logic dcsr_step_i,
  input  logic debug_req_i,
  input  logic irq_wake_i,
  input  logic ibus_busy_i,
  input  logic dbus_busy_i,
  input  logic write_buf_empty_i,
  output logic core_sleep_o,
  output logic wb_retire_o
);
  import irq_sleep_pkg::*;

  logic [SleepEntryDelay-1:0] wfi_dly_q;
  logic                       sleep_q;
  logic                       blocked;
  logic                       wake;
  logic                       first_cycle;
  logic                       sleep_set;

  assign blocked = ibus_busy_i || dbus_busy_i || !write_buf_empty_i;
  assign wake    = irq_wake_i || debug_req_i;

  // --------------------------------------------------------------------------
  // Writeback delay line and sleep flag
  // --------------------------------------------------------------------------
  assign first_cycle = wfi_in_wb_i && !wfi_dly_q[0];
  assign sleep_set   = wfi_in_wb_i && (&wfi_dly_q) && !blocked && !wake;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wfi_dly_q <= '0;
      sleep_q   <= 1'b0;
    end else begin
      wfi_dly_q <= {wfi_dly_q[SleepEntryDelay-2:0], wfi_in_wb_i};
      if (!wfi_in_wb_i || wake) begin
        sleep_q <= 1'b0;
      end else if (sleep_set) begin
        sleep_q <= 1'b1;
      end
    end
  end

  // Drops in the same cycle as a wake source
  assign core_sleep_o = sleep_q && !blocked && !wake;

  // First cycle retires only on a step, later cycles only on wake
  assign wb_retire_o = first_cycle ? (dcsr_step_i && !debug_req_i)
                                   : (wfi_in_wb_i && wake);

  a_no_sleep_blocked: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(core_sleep_o) |-> !blocked && $past(!blocked));

  a_no_early_sleep: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(wfi_in_wb_i) |-> !core_sleep_o ##1 !core_sleep_o ##1 !core_sleep_o);

  a_no_retire_waiting: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wfi_in_wb_i && $past(wfi_in_wb_i) && !wake |-> !wb_retire_o);

endmodule

/* tb_irq_sleep_unit.sv */
module tb_irq_sleep_unit;
  timeunit 1ns;
  timeprecision 100ps;
  import irq_sleep_pkg::*;

  localparam logic [31:0] WfiCode = 32'h1050_0073;
  localparam logic [31:0] WfeCode = 32'h8c00_0073;
  // Lines 31..16, external 11, timer 7, software 3
  localparam logic [31:0] UsableLines = {16'hffff, 16'b0000_1000_1000_1000};
  localparam int WaitLimit = 40;

  logic        clk_i;
  logic        rst_ni;
  irq_vec_t    irq_i;
  irq_vec_t    mip_o;
  csr_wr_t     csr_wr_i;
  priv_lvl_e   priv_i;
  logic        mret_i;
  logic        debug_mode_i;
  logic        debug_req_i;
  logic        dcsr_step_i;
  logic        write_buf_empty_i;
  wb_instr_t   wb_instr_i;
  bus_strobe_t ibus_i;
  bus_strobe_t dbus_i;
  logic        irq_ack_o;
  logic        core_sleep_o;
  logic        wb_retire_o;
  irq_id_t     irq_id_o;
  csr_state_t  csr_o;

  logic [31:0] irq_prev;
  logic [31:0] pend_en;
  logic [4:0]  last_ack_id;
  logic        ack_locked;
  logic        wake_line;
  logic        wfi_held;
  logic        chk_mip;
  logic        chk_entry;
  int          dbus_out;
  logic [31:0] rng_state;
  string       cur_test;
  int          err_cnt;
  int          err_at_start;
  int          tests_run;
  int          tests_failed;

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  irq_sleep_unit irq_sleep_unit_inst (.*);

  // --------------------------------------------------------------------------
  // Reference models
  // --------------------------------------------------------------------------

  // Platform lines from the top down, then external, software, timer
  function automatic logic [4:0] top_priority(input logic [31:0] vec);
    for (int i = 31; i >= 16; i--) begin
      if (vec[i]) begin
        return 5'(i);
      end
    end
    if (vec[11]) begin
      return 5'd11;
    end
    return vec[3] ? 5'd3 : 5'd7;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  assign pend_en   = mip_o & csr_o.mie;
  assign wake_line = |(irq_i & UsableLines & csr_o.mie);
  assign wfi_held  = wb_instr_i.valid &&
                     (wb_instr_i.data == WfiCode || wb_instr_i.data == WfeCode);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_prev    <= '0;
      last_ack_id <= '0;
      ack_locked  <= 1'b0;
      dbus_out    <= 0;
    end else begin
      irq_prev <= irq_i;
      // Trap entry locks out acknowledges until software re-enables
      if (irq_ack_o) begin
        last_ack_id <= top_priority(pend_en);
        ack_locked  <= 1'b1;
      end else if (mret_i || csr_wr_i.valid) begin
        ack_locked <= 1'b0;
      end
      if (dbus_i.req && dbus_i.gnt && !dbus_i.rvalid) begin
        dbus_out <= dbus_out + 1;
      end else if (dbus_i.rvalid && !(dbus_i.req && dbus_i.gnt)) begin
        dbus_out <= dbus_out - 1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  a_mip_registered: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_mip |-> mip_o == (irq_prev & UsableLines))
    else report_value("mip_o", $sampled(irq_prev & UsableLines), $sampled(mip_o));

  a_ack_winner: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> irq_id_o == top_priority(pend_en))
    else report_value("irq_id_o", top_priority($sampled(pend_en)), $sampled(irq_id_o));

  a_mcause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |=> csr_o.mcause == {1'b1, last_ack_id})
    else report_value("mcause", {1'b1, $sampled(last_ack_id)}, $sampled(csr_o.mcause));

  a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |=> !irq_ack_o)
    else report_error("irq_ack_o high in two consecutive cycles");

  a_ack_locked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_locked |-> !irq_ack_o)
    else report_error("irq_ack_o repeated before mret or a CSR write");

  // Sleep starts on the fourth sampled cycle of the wait, not before
  a_sleep_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_entry && $rose(wfi_held) |->
      !core_sleep_o ##1 !core_sleep_o ##1 !core_sleep_o ##1 core_sleep_o)
    else report_error("core_sleep_o did not rise exactly three cycles after the WFI");

  a_sleep_blocked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbus_out != 0 |-> !core_sleep_o)
    else report_error("core_sleep_o high with a data-bus response outstanding");

  a_irq_wake: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o && $rose(wake_line) |=> !core_sleep_o && wb_retire_o)
    else report_error("enabled interrupt did not wake the core and retire the WFI");

  a_debug_wake: assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_req_i |-> !core_sleep_o)
    else report_error("core_sleep_o stayed high during debug_req_i");

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  task automatic report_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    err_cnt++;
    $display("Fail %s: %s expected %h actual %h", cur_test, what, exp, act);
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("Error in %s: %s", cur_test, what);
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = err_cnt;
  endtask

  task automatic finish_test();
    repeat (2) next_cycle();
    tests_run++;
    if (err_cnt == err_at_start) begin
      $display("Test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", cur_test, err_cnt - err_at_start);
    end
  endtask

  task automatic csr_write(input csr_sel_e sel, input logic [31:0] data);
    csr_wr_i = '{valid: 1'b1, sel: sel, data: data};
    next_cycle();
    csr_wr_i.valid = 1'b0;
  endtask

  task automatic pulse_mret();
    mret_i = 1'b1;
    priv_i = PrivM;
    next_cycle();
    mret_i = 1'b0;
    next_cycle();
  endtask

  task automatic wait_until(input logic for_sleep);
    int n;
    n = 0;
    while (!(for_sleep ? core_sleep_o : irq_ack_o) && n < WaitLimit) begin
      next_cycle();
      n++;
    end
    if (!(for_sleep ? core_sleep_o : irq_ack_o)) begin
      report_error(for_sleep ? "timeout waiting for core_sleep_o"
                             : "timeout waiting for irq_ack_o");
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] vec;
    logic [31:0] mask;
    rst_ni            = 1'b0;
    irq_i             = '0;
    csr_wr_i          = '0;
    mret_i            = 1'b0;
    priv_i            = PrivM;
    debug_mode_i      = 1'b0;
    debug_req_i       = 1'b0;
    dcsr_step_i       = 1'b0;
    wb_instr_i        = '0;
    ibus_i            = '0;
    dbus_i            = '0;
    write_buf_empty_i = 1'b1;
    chk_mip           = 1'b0;
    chk_entry         = 1'b0;
    rng_state         = 32'd41965;
    err_cnt           = 0;
    tests_run         = 0;
    tests_failed      = 0;
    cur_test          = "reset";
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    next_cycle();

    // Interrupts stay globally disabled out of reset
    start_test("mip_capture");
    chk_mip = 1'b1;
    for (int i = 0; i < 200; i++) begin
      irq_i = next_random();
      next_cycle();
    end
    irq_i = '0;
    next_cycle();
    chk_mip = 1'b0;
    finish_test();

    start_test("ack_priority");
    csr_write(CsrMstatus, 32'h0000_0008);
    for (int i = 0; i < 40; i++) begin
      vec  = next_random();
      mask = next_random();
      if ((vec & mask & UsableLines) == '0) begin
        vec[3]  = 1'b1;
        mask[3] = 1'b1;
      end
      csr_write(CsrMie, mask);
      irq_i = vec;
      wait_until(1'b0);
      irq_i = '0;
      next_cycle();
      pulse_mret();
    end
    finish_test();

    // Line stays pending while the handler runs with interrupts off
    start_test("ack_pulse");
    csr_write(CsrMie, '1);
    irq_i = 32'h0001_0000 << (next_random() % 16);
    wait_until(1'b0);
    repeat (6) next_cycle();
    csr_write(CsrMstatus, 32'h0000_0088);
    wait_until(1'b0);
    irq_i = '0;
    next_cycle();
    pulse_mret();
    finish_test();

    start_test("sleep_entry");
    chk_entry        = 1'b1;
    wb_instr_i.data  = WfiCode;
    wb_instr_i.valid = 1'b1;
    wait_until(1'b1);
    repeat (2) next_cycle();
    wb_instr_i.valid = 1'b0;
    repeat (2) next_cycle();
    chk_entry = 1'b0;
    finish_test();

    start_test("sleep_bus_pending");
    dbus_i = '{req: 1'b1, gnt: 1'b1, rvalid: 1'b0};
    next_cycle();
    dbus_i           = '0;
    wb_instr_i.valid = 1'b1;
    repeat (10) next_cycle();
    dbus_i.rvalid = 1'b1;
    next_cycle();
    dbus_i.rvalid = 1'b0;
    wait_until(1'b1);
    next_cycle();
    wb_instr_i.valid = 1'b0;
    finish_test();

    start_test("sleep_wake");
    csr_write(CsrMstatus, '0);
    wb_instr_i.valid = 1'b1;
    wait_until(1'b1);
    vec = next_random() & UsableLines;
    if (vec == '0) begin
      vec = 32'h0000_0800;
    end
    irq_i = vec;
    repeat (2) next_cycle();
    irq_i            = '0;
    wb_instr_i.valid = 1'b0;
    repeat (3) next_cycle();
    wb_instr_i.data  = WfeCode;
    wb_instr_i.valid = 1'b1;
    wait_until(1'b1);
    debug_req_i = 1'b1;
    next_cycle();
    debug_req_i      = 1'b0;
    wb_instr_i.valid = 1'b0;
    finish_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
irq_sleep_pkg.sv
irq_csr.sv
irq_arbiter.sv
bus_outstanding_cnt.sv
wfi_decode.sv
sleep_ctrl.sv
irq_sleep_unit.sv
tb_irq_sleep_unit.sv

/* wfi_decode.sv */
module wfi_decode (
  input  irq_sleep_pkg::wb_instr_t  wb_instr_i,
  input  irq_sleep_pkg::csr_state_t csr_i,
  input  logic                      debug_mode_i,
  input  logic                      dcsr_step_i,
  output logic                      wfi_in_wb_o
);
  import irq_sleep_pkg::*;

  logic is_wfi;
  logic is_wfe;
  logic bus_fault;
  logic tw_trap;
  logic invalidated;

  // --------------------------------------------------------------------------
  // Encoding match
  // --------------------------------------------------------------------------
  assign is_wfi = (wb_instr_i.data == WfiInstr);
  assign is_wfe = (wb_instr_i.data == WfeInstr);

  // --------------------------------------------------------------------------
  // Conditions that turn the wait into a no-op or a trap
  // --------------------------------------------------------------------------

  // Fetch error or MPU fault means the instruction will trap instead
  assign bus_fault = wb_instr_i.err || wb_instr_i.mpu_fault;

  // Timeout wait makes WFI illegal in user mode
  assign tw_trap = (csr_i.priv_lvl == PrivU) && csr_i.mstatus_tw;

  // Single stepping never sleeps
  assign invalidated = !wb_instr_i.valid ||
                       bus_fault         ||
                       wb_instr_i.kill   ||
                       debug_mode_i      ||
                       dcsr_step_i       ||
                       tw_trap;

  assign wfi_in_wb_o = (is_wfi || is_wfe) && !invalidated;

endmodule
